// File: logic/ipod_pkg.sv
package ipod_pkg;

  // ==================================================
  // Widths
  // ==================================================

  // Sample address, bit 0 picks the half of a flash word
  typedef logic [23:0] addr_t;

  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_data_t;
  typedef logic [15:0] sample_t;

  // Clock cycles per half sample period
  typedef logic [15:0] half_period_t;

  // ==================================================
  // Flash port and command structs
  // ==================================================

  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  typedef struct packed {
    flash_data_t readdata;
    logic        readdatavalid;
  } flash_rsp_t;

  // One-cycle speed requests
  typedef struct packed {
    logic up;
    logic down;
    logic restore;
  } speed_cmd_t;

  // Upper case ASCII command letters
  localparam logic [7:0] KEY_PLAY  = 8'h45;  // E
  localparam logic [7:0] KEY_PAUSE = 8'h44;  // D
  localparam logic [7:0] KEY_FWD   = 8'h46;  // F
  localparam logic [7:0] KEY_BACK  = 8'h42;  // B

  // Top of the sample address space
  localparam addr_t LAST_ADDR = 24'hFF_FFFF;

endpackage

// File: logic/player_ctrl.sv
module player_ctrl import ipod_pkg::*; #(
  parameter half_period_t freq_base  = 16'd11000,
  parameter half_period_t speed_step = 16'd100
) (
  input  logic         CLK_50M,
  input  logic         rst,
  input  logic [7:0]   key_ascii,
  input  logic         key_valid,
  input  speed_cmd_t   speed_cmd,
  output logic         playing,
  output logic         forward,
  output half_period_t half_period
);

  // Saturation bounds of the half-period
  localparam half_period_t HP_MIN = speed_step;
  localparam half_period_t HP_MAX = 16'hFFFF - speed_step;

  logic [7:0]   key_upper;
  logic         cmd_play;
  logic         cmd_pause;
  logic         cmd_fwd;
  logic         cmd_back;

  logic [16:0]  hp_sum;
  logic [16:0]  hp_diff;
  half_period_t hp_faster;
  half_period_t hp_slower;
  logic         step_up;
  logic         step_down;

  // ==================================================
  // Key decode
  // ==================================================

  // Clearing bit 5 folds lower case onto upper case
  assign key_upper = key_ascii & 8'hDF;

  assign cmd_play  = key_valid && (key_upper == KEY_PLAY);
  assign cmd_pause = key_valid && (key_upper == KEY_PAUSE);
  assign cmd_fwd   = key_valid && (key_upper == KEY_FWD);
  assign cmd_back  = key_valid && (key_upper == KEY_BACK);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      playing <= 1'b0;
      forward <= 1'b1;
    end
    else
    begin
      if (cmd_play)
        playing <= 1'b1;
      else if (cmd_pause)
        playing <= 1'b0;

      if (cmd_fwd)
        forward <= 1'b1;
      else if (cmd_back)
        forward <= 1'b0;
    end
  end

  // ==================================================
  // Speed register
  // ==================================================

  // Up and down together cancel out
  assign step_up   = speed_cmd.up && !speed_cmd.down;
  assign step_down = speed_cmd.down && !speed_cmd.up;

  assign hp_sum  = {1'b0, half_period} + {1'b0, speed_step};
  assign hp_diff = {1'b0, half_period} - {1'b0, speed_step};

  // Shorter half-period means faster playback
  always_comb
  begin
    if (hp_diff[16] || (hp_diff[15:0] < HP_MIN))
      hp_faster = HP_MIN;
    else
      hp_faster = hp_diff[15:0];
  end

  always_comb
  begin
    if (hp_sum > {1'b0, HP_MAX})
      hp_slower = HP_MAX;
    else
      hp_slower = hp_sum[15:0];
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      half_period <= freq_base;
    else if (speed_cmd.restore)
      half_period <= freq_base;
    else if (step_up)
      half_period <= hp_faster;
    else if (step_down)
      half_period <= hp_slower;
  end

endmodule

// File: logic/sample_tick_gen.sv
module sample_tick_gen import ipod_pkg::*; (
  input  logic         CLK_50M,
  input  logic         rst,
  input  half_period_t half_period,
  output logic         tick
);

  // Counter spans a full period, so one bit wider than the half-period
  logic [16:0] count;
  logic [16:0] reload_val;

  // Full period minus one, the counter stops on zero
  assign reload_val = {half_period, 1'b0} - 17'd1;

  // ==================================================
  // Period counter
  // ==================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      // New half_period is picked up only here
      count <= reload_val;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 17'd1;
      tick  <= 1'b0;
    end
  end

endmodule

// File: logic/flash_reader.sv
module flash_reader import ipod_pkg::*; (
  input  logic       CLK_50M,
  input  logic       rst,
  input  logic       tick,
  input  logic       playing,
  input  logic       forward,
  input  flash_rsp_t flash_rsp,
  output flash_req_t flash_req,
  output sample_t    sample,
  output logic       sample_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_step,
    st_request,
    st_wait
  } state_t;

  state_t  state;
  addr_t   addr;
  addr_t   addr_next;
  sample_t word_half;

  // ==================================================
  // Address stepping
  // ==================================================

  // Wrap at both ends of the sample space
  always_comb
  begin
    if (forward)
    begin
      if (addr == LAST_ADDR)
        addr_next = '0;
      else
        addr_next = addr + 24'd1;
    end
    else
    begin
      if (addr == '0)
        addr_next = LAST_ADDR;
      else
        addr_next = addr - 24'd1;
    end
  end

  // Odd addresses take the upper half of the word
  assign word_half = addr[0] ? flash_rsp.readdata[31:16] : flash_rsp.readdata[15:0];

  // ==================================================
  // Read FSM
  // ==================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state <= st_idle;
      addr  <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          // Ticks while paused are simply dropped
          if (tick && playing)
            state <= st_step;
        end
        st_step:
        begin
          addr  <= addr_next;
          state <= st_request;
        end
        st_request:
        begin
          state <= st_wait;
        end
        st_wait:
        begin
          if (flash_rsp.readdatavalid)
            state <= st_idle;
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  // One-cycle read with the word address held
  assign flash_req.read    = (state == st_request);
  assign flash_req.address = addr[23:1];

  // ==================================================
  // Sample capture
  // ==================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      sample       <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      if ((state == st_wait) && flash_rsp.readdatavalid)
      begin
        sample       <= word_half;
        sample_valid <= 1'b1;
      end
    end
  end

endmodule

// File: logic/ipod_player.sv
module ipod_player import ipod_pkg::*; #(
  parameter half_period_t freq_base  = 16'd11000,
  parameter half_period_t speed_step = 16'd100
) (
  input  logic         CLK_50M,
  input  logic         rst,

  // Keyboard and speed strobes
  input  logic [7:0]   key_ascii,
  input  logic         key_valid,
  input  speed_cmd_t   speed_cmd,

  // Flash port
  input  flash_rsp_t   flash_rsp,
  output flash_req_t   flash_req,

  // Audio sample out
  output sample_t      sample,
  output logic         sample_valid,

  // Status
  output logic         playing,
  output logic         forward
);

  half_period_t half_period;
  logic         tick;

  // ==================================================
  // Command and speed registers
  // ==================================================

  player_ctrl #(
    .freq_base  (freq_base),
    .speed_step (speed_step)
  ) u_player_ctrl (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .key_ascii   (key_ascii),
    .key_valid   (key_valid),
    .speed_cmd   (speed_cmd),
    .playing     (playing),
    .forward     (forward),
    .half_period (half_period)
  );

  // ==================================================
  // Sample rate
  // ==================================================

  sample_tick_gen u_sample_tick_gen (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .half_period (half_period),
    .tick        (tick)
  );

  // ==================================================
  // Flash address and data path
  // ==================================================

  flash_reader u_flash_reader (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .tick         (tick),
    .playing      (playing),
    .forward      (forward),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

endmodule

// File: test/tb_flash_model.sv
module tb_flash_model import ipod_pkg::*; (
  input  logic       CLK_50M,
  input  logic       rst,
  input  flash_req_t flash_req,
  output flash_rsp_t flash_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  integer      seed = 74697;
  logic        pending;
  int          delay;
  flash_addr_t word_addr;

  // ==================================================
  // Read responder
  // ==================================================

  // Works 2 ns after each edge, where the read strobe is stable
  initial
  begin
    flash_rsp = '0;
    pending   = 1'b0;
    delay     = 0;
    word_addr = '0;
    forever
    begin
      @(posedge CLK_50M);
      #2;
      flash_rsp.readdatavalid = 1'b0;
      if (rst)
      begin
        pending = 1'b0;
      end
      else if (pending)
      begin
        delay--;
        if (delay == 0)
        begin
          // Inverted word address on top, plain word address below
          flash_rsp.readdata      = {~word_addr[15:0], word_addr[15:0]};
          flash_rsp.readdatavalid = 1'b1;
          pending                 = 1'b0;
        end
      end
      else if (flash_req.read)
      begin
        word_addr = flash_req.address;
        delay     = 1 + ($random(seed) & 32'h3);
        pending   = 1'b1;
      end
    end
  end

endmodule

// File: test/ipod_player_sva.sv
module ipod_player_sva import ipod_pkg::*; (
  input logic       CLK_50M,
  input logic       rst,
  input flash_req_t flash_req,
  input flash_rsp_t flash_rsp,
  input logic       sample_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_fails = 0;
  logic        outstanding;

  // Set by a read, cleared by its response
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      outstanding <= 1'b0;
    else if (flash_req.read)
      outstanding <= 1'b1;
    else if (flash_rsp.readdatavalid)
      outstanding <= 1'b0;
  end

  // ==================================================
  // Flash read rules
  // ==================================================

  read_one_cycle: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_req.read |=> !flash_req.read)
    else
    begin
      assert_fails++;
      $error("flash read held for more than one cycle");
    end

  read_while_busy: assert property (@(posedge CLK_50M) disable iff (rst)
    outstanding |-> !flash_req.read)
    else
    begin
      assert_fails++;
      $error("flash read issued while a response is outstanding");
    end

  sample_after_data: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_rsp.readdatavalid |=> sample_valid)
    else
    begin
      assert_fails++;
      $error("sample_valid missing one cycle after readdatavalid");
    end

  sample_without_data: assert property (@(posedge CLK_50M) disable iff (rst)
    sample_valid |-> $past(flash_rsp.readdatavalid))
    else
    begin
      assert_fails++;
      $error("sample_valid without readdatavalid in the cycle before");
    end

endmodule

bind flash_reader ipod_player_sva u_ipod_player_sva (
  .CLK_50M      (CLK_50M),
  .rst          (rst),
  .flash_req    (flash_req),
  .flash_rsp    (flash_rsp),
  .sample_valid (sample_valid)
);

// File: test/ipod_player_tb.sv
module ipod_player_tb import ipod_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FREQ_BASE  = 40;
  localparam int SPEED_STEP = 8;
  // Three of the longest possible periods
  localparam int LONG_WAIT  = 6 * 65535 + 200;

  logic       CLK_50M;
  logic       rst;
  logic [7:0] key_ascii;
  logic       key_valid;
  speed_cmd_t speed_cmd;
  flash_rsp_t flash_rsp;
  flash_req_t flash_req;
  sample_t    sample;
  logic       sample_valid;
  logic       playing;
  logic       forward;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          model_hp;
  addr_t       exp_addr;
  logic        dir_model;
  longint      cycle_count;
  flash_addr_t read_word;
  addr_t       seen_addr[$];
  longint      read_cycles[$];

  ipod_player #(
    .freq_base  (FREQ_BASE),
    .speed_step (SPEED_STEP)
  ) u_ipod_player (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .key_ascii    (key_ascii),
    .key_valid    (key_valid),
    .speed_cmd    (speed_cmd),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .sample       (sample),
    .sample_valid (sample_valid),
    .playing      (playing),
    .forward      (forward)
  );

  tb_flash_model u_flash_model (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==================================================
  // Reference model
  // ==================================================

  function automatic addr_t ref_next_addr(input addr_t a, input logic fwd);
    if (fwd)
      return (a == LAST_ADDR) ? 24'd0 : a + 24'd1;
    return (a == 24'd0) ? LAST_ADDR : a - 24'd1;
  endfunction

  // Odd sample address reads the upper half of its flash word
  function automatic sample_t ref_sample(input addr_t a);
    flash_addr_t word;
    word = a[23:1];
    return a[0] ? ~word[15:0] : word[15:0];
  endfunction

  function automatic int ref_half_period(input int hp, input logic up, input logic down,
                                         input logic restore);
    if (restore)
      return FREQ_BASE;
    if (up && !down)
      return (hp - SPEED_STEP < SPEED_STEP) ? SPEED_STEP : hp - SPEED_STEP;
    if (down && !up)
      return (hp + SPEED_STEP > 65535 - SPEED_STEP) ? 65535 - SPEED_STEP : hp + SPEED_STEP;
    return hp;
  endfunction

  // ==================================================
  // Checks and stimulus tasks
  // ==================================================

  task automatic check_hex(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("MISMATCH %s expected 0x%0h got 0x%0h", name, expected, got);
      errors++;
    end
  endtask

  task automatic check_addr(input int index, input addr_t expected);
    if (index < seen_addr.size())
      check_hex("sample address", seen_addr[index], expected);
  endtask

  task automatic press_key(input logic [7:0] code);
    @(posedge CLK_50M);
    #2;
    key_ascii = code;
    key_valid = 1'b1;
    if ((code & 8'hDF) == KEY_FWD)
      dir_model = 1'b1;
    else if ((code & 8'hDF) == KEY_BACK)
      dir_model = 1'b0;
    @(posedge CLK_50M);
    #2;
    key_valid = 1'b0;
    key_ascii = 8'h00;
  endtask

  // Holding a strobe for n cycles counts as n requests
  task automatic apply_speed(input logic up_req, input logic down_req,
                             input logic restore_req, input int count);
    @(posedge CLK_50M);
    #2;
    speed_cmd.up      = up_req;
    speed_cmd.down    = down_req;
    speed_cmd.restore = restore_req;
    repeat (count)
    begin
      model_hp = ref_half_period(model_hp, up_req, down_req, restore_req);
      @(posedge CLK_50M);
      #2;
    end
    speed_cmd = '0;
  endtask

  task automatic apply_reset();
    @(posedge CLK_50M);
    #2;
    rst       = 1'b1;
    exp_addr  = '0;
    dir_model = 1'b1;
    model_hp  = FREQ_BASE;
    repeat (8) @(posedge CLK_50M);
    #2;
    rst = 1'b0;
  endtask

  task automatic wait_samples(input int target, input string what);
    int waited;
    waited = 0;
    while ((seen_addr.size() < target) && (waited < 200 * target))
    begin
      @(posedge CLK_50M);
      #3;
      waited++;
    end
    if (seen_addr.size() < target)
    begin
      $display("Timeout while waiting for audio samples in %s", what);
      errors++;
    end
  endtask

  task automatic wait_reads(input int target, input string what);
    int waited;
    waited = 0;
    while ((read_cycles.size() < target) && (waited < LONG_WAIT))
    begin
      @(posedge CLK_50M);
      #3;
      waited++;
    end
    if (read_cycles.size() < target)
    begin
      $display("Timeout while waiting for flash reads in %s", what);
      errors++;
    end
  endtask

  // The first interval after a change may still run at the old rate
  task automatic check_interval(input string what);
    int base;
    base = read_cycles.size();
    wait_reads(base + 3, what);
    if (read_cycles.size() >= base + 3)
      check_hex({what, " read interval"}, read_cycles[base + 2] - read_cycles[base + 1],
                2 * model_hp);
  endtask

  task automatic finish_test(input string name, input int first_err);
    tests_run++;
    if (errors > first_err)
    begin
      tests_failed++;
      $display("%-20s failed with %0d errors", name, errors - first_err);
    end
    else
      $display("%-20s passed", name);
  endtask

  // ==================================================
  // Comparison process
  // ==================================================

  initial
  begin
    cycle_count = 0;
    read_word   = '0;
    forever
    begin
      @(posedge CLK_50M);
      #1;
      cycle_count++;
      if (!rst && flash_req.read)
      begin
        exp_addr  = ref_next_addr(exp_addr, dir_model);
        read_word = flash_req.address;
        read_cycles.push_back(cycle_count);
        check_hex("flash_req.address", flash_req.address, exp_addr[23:1]);
      end
      if (!rst && sample_valid)
      begin
        // Sample address rebuilt from the word read and the half returned
        seen_addr.push_back({read_word, sample == ~read_word[15:0]});
        check_hex("sample", sample, ref_sample(exp_addr));
      end
    end
  end

  // ==================================================
  // Test sequence
  // ==================================================

  initial
  begin
    int    first_err;
    int    base;
    addr_t held;
    rst          = 1'b1;
    key_ascii    = 8'h00;
    key_valid    = 1'b0;
    speed_cmd    = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    apply_reset();

    first_err = errors;
    check_hex("playing", playing, 1'b0);
    check_hex("forward", forward, 1'b1);
    check_hex("sample", sample, 16'h0000);
    repeat (500) @(posedge CLK_50M);
    #3;
    check_hex("reads after reset", read_cycles.size(), 0);
    check_hex("samples after reset", seen_addr.size(), 0);
    finish_test("reset state", first_err);

    first_err = errors;
    press_key(8'h65);
    wait_samples(4, "forward play");
    for (int i = 0; i < 4; i++)
      check_addr(i, i + 1);
    finish_test("forward play", first_err);

    first_err = errors;
    press_key(8'h44);
    base = read_cycles.size();
    repeat (3 * 2 * FREQ_BASE) @(posedge CLK_50M);
    #3;
    check_hex("reads while paused", read_cycles.size() - base, 0);
    base = seen_addr.size();
    held = (base > 0) ? seen_addr[base - 1] : '0;
    press_key(8'h45);
    wait_samples(base + 2, "pause and resume");
    check_addr(base, ref_next_addr(held, 1'b1));
    check_addr(base + 1, ref_next_addr(ref_next_addr(held, 1'b1), 1'b1));
    finish_test("pause and resume", first_err);

    first_err = errors;
    press_key(8'h64);
    apply_reset();
    press_key(8'h62);
    press_key(8'h65);
    base = seen_addr.size();
    wait_samples(base + 3, "backward play");
    check_addr(base, LAST_ADDR);
    check_addr(base + 1, LAST_ADDR - 24'd1);
    check_addr(base + 2, LAST_ADDR - 24'd2);
    press_key(8'h66);
    wait_samples(base + 5, "backward play");
    check_addr(base + 3, LAST_ADDR - 24'd1);
    check_addr(base + 4, LAST_ADDR);
    finish_test("backward play", first_err);

    first_err = errors;
    check_interval("base rate");
    apply_speed(1'b1, 1'b0, 1'b0, 1);
    check_interval("one up");
    apply_speed(1'b0, 1'b1, 1'b0, 2);
    check_interval("two down");
    apply_speed(1'b1, 1'b1, 1'b0, 1);
    check_interval("up with down");
    apply_speed(1'b1, 1'b0, 1'b0, 6);
    check_interval("up to floor");
    apply_speed(1'b0, 1'b1, 1'b0, 8200);
    check_interval("down to ceiling");
    apply_speed(1'b0, 1'b0, 1'b1, 1);
    check_interval("restore");
    finish_test("speed control", first_err);

    errors += u_ipod_player.u_flash_reader.u_ipod_player_sva.assert_fails;
    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: compile.f
logic/ipod_pkg.sv
logic/player_ctrl.sv
logic/sample_tick_gen.sv
logic/flash_reader.sv
logic/ipod_player.sv
test/tb_flash_model.sv
test/ipod_player_sva.sv
test/ipod_player_tb.sv
